/* Bender.yml */
package:
  name: lsu_pipeline

sources:
  # Packages first, then the RTL
  - design/riscv_isa_pkg.sv
  - design/dcache_pkg.sv
  - design/store_align.sv
  - design/mem_stage_pipe.sv
  - design/load_extract.sv
  - design/lsu_pipeline.sv

  # Testbench with its reference model header
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_lsu_pipeline.sv

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    import riscv_isa_pkg::*;

    // Request codes towards the data cache
    typedef logic [1:0] dcache_ctrl_t;

    localparam dcache_ctrl_t DC_IDLE  = 2'b00;
    localparam dcache_ctrl_t DC_READ  = 2'b01;
    localparam dcache_ctrl_t DC_WRITE = 2'b10;

    // One enable per byte lane with lane 0 on bits 7:0
    typedef logic [3:0] byte_en_t;

    typedef struct packed {
        dcache_ctrl_t ctrl;
        word_t        addr;
        byte_en_t     byte_en;
        word_t        wdata;
    } dcache_req_t;

endpackage

`default_nettype wire

/* design/load_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module load_extract
    import riscv_isa_pkg::*;
(
    input  stage_t wb_stage,
    input  word_t  rdata,
    output wb_t    wb
);

    logic [1:0] offset;
    word_t      lane_data;
    word_t      load_value;
    logic       is_load;

    assign offset  = wb_stage.result[1:0];
    assign is_load = (wb_stage.kind == KIND_LOAD);

    // Addressed byte or halfword moved down to bit 0
    assign lane_data = rdata >> {offset, 3'b000};

    //////////////////////////////
    // Width and extension
    //////////////////////////////

    always_comb
    begin
        case (wb_stage.funct3)
            F3_LB:
            begin
                load_value = {{24{lane_data[7]}}, lane_data[7:0]};
            end
            F3_LH:
            begin
                load_value = {{16{lane_data[15]}}, lane_data[15:0]};
            end
            F3_LBU:
            begin
                load_value = {24'd0, lane_data[7:0]};
            end
            F3_LHU:
            begin
                load_value = {16'd0, lane_data[15:0]};
            end
            default:
            begin
                load_value = rdata;
            end
        endcase
    end

    // x0 is never written
    assign wb.en   = (is_load || wb_stage.kind == KIND_ALU) && wb_stage.rd != '0;
    assign wb.rd   = wb_stage.rd;
    assign wb.data = is_load ? load_value : wb_stage.result;

endmodule

`default_nettype wire

/* design/lsu_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipeline
    import riscv_isa_pkg::*;
    import dcache_pkg::*;
#(
    parameter int MEM_LATENCY = 3
) (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        data_ready,
    input  mem_op_t     ex_op,
    input  word_t       rdata,
    output dcache_req_t dcache_req,
    output wb_t         wb,
    output word_t       return_addr
);

    stage_t wb_stage;

    //////////////////////////////
    // Request side
    //////////////////////////////

    store_align u_store_align (
        .ex_op (ex_op),
        .req   (dcache_req)
    );

    //////////////////////////////
    // Latency stages
    //////////////////////////////

    mem_stage_pipe #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem_stage_pipe (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .data_ready  (data_ready),
        .ex_op       (ex_op),
        .wb_stage    (wb_stage),
        .return_addr (return_addr),
        .wb_data     (wb.data)
    );

    // Writeback value from the cache word
    load_extract u_load_extract (
        .wb_stage (wb_stage),
        .rdata    (rdata),
        .wb       (wb)
    );

endmodule

`default_nettype wire

/* design/mem_stage_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_pipe
    import riscv_isa_pkg::*;
#(
    parameter int MEM_LATENCY = 3
) (
    input  logic    CLK,
    input  logic    arst_n,
    input  logic    data_ready,
    input  mem_op_t ex_op,
    output stage_t  wb_stage,
    output word_t   return_addr,
    input  word_t   wb_data
);

    localparam stage_t IDLE_STAGE = '{
        kind:   KIND_IDLE,
        funct3: '0,
        rd:     '0,
        result: '0
    };

    stage_t mem_q [MEM_LATENCY];
    stage_t wb_q;
    stage_t entry;
    logic   writes_link;

    // Store data has left with the cache request
    assign entry = '{
        kind:   ex_op.kind,
        funct3: ex_op.funct3,
        rd:     ex_op.rd,
        result: ex_op.result
    };

    //////////////////////////////
    // Memory stages and writeback
    //////////////////////////////

    // Whole chain freezes while the cache is busy
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_LATENCY; i++)
            begin
                mem_q[i] <= IDLE_STAGE;
            end
            wb_q <= IDLE_STAGE;
        end
        else if (data_ready)
        begin
            mem_q[0] <= entry;
            for (int i = 1; i < MEM_LATENCY; i++)
            begin
                mem_q[i] <= mem_q[i-1];
            end
            wb_q <= mem_q[MEM_LATENCY-1];
        end
    end

    assign wb_stage = wb_q;

    //////////////////////////////
    // Return address shadow
    //////////////////////////////

    assign writes_link = (wb_q.kind == KIND_LOAD || wb_q.kind == KIND_ALU)
                         && wb_q.rd == LINK_REG;

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            return_addr <= '0;
        end
        else if (data_ready && writes_link)
        begin
            return_addr <= wb_data;
        end
    end

    // A stalled cycle must not drop or repeat a writeback
    wb_held_on_stall: assert property (@(posedge CLK) disable iff (!arst_n)
        !data_ready |=> $stable(wb_stage) && $stable(return_addr));

endmodule

`default_nettype wire

/* design/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  op_kind_t;
    typedef logic [2:0]  funct3_t;

    localparam op_kind_t KIND_IDLE  = 2'd0;
    localparam op_kind_t KIND_ALU   = 2'd1;
    localparam op_kind_t KIND_LOAD  = 2'd2;
    localparam op_kind_t KIND_STORE = 2'd3;

    // Load and store width codes share encodings
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    localparam reg_idx_t LINK_REG = 5'd1;

    //////////////////////////////
    // Operation records
    //////////////////////////////

    // result holds the effective address for loads and stores
    typedef struct packed {
        op_kind_t kind;
        funct3_t  funct3;
        reg_idx_t rd;
        word_t    result;
        word_t    store_data;
    } mem_op_t;

    typedef struct packed {
        op_kind_t kind;
        funct3_t  funct3;
        reg_idx_t rd;
        word_t    result;
    } stage_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* design/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align
    import riscv_isa_pkg::*;
    import dcache_pkg::*;
(
    input  mem_op_t     ex_op,
    output dcache_req_t req
);

    logic [1:0] offset;
    logic       is_store;

    assign offset   = ex_op.result[1:0];
    assign is_store = (ex_op.kind == KIND_STORE);

    always_comb
    begin
        case (ex_op.kind)
            KIND_LOAD:  req.ctrl = DC_READ;
            KIND_STORE: req.ctrl = DC_WRITE;
            default:    req.ctrl = DC_IDLE;
        endcase
    end

    assign req.addr = {ex_op.result[31:2], 2'b00};

    //////////////////////////////
    // Lane enables
    //////////////////////////////

    always_comb
    begin
        req.byte_en = 4'b0000;
        if (is_store)
        begin
            case (ex_op.funct3)
                F3_SW: req.byte_en = 4'b1111;
                F3_SH:
                begin
                    case (offset)
                        2'd0:    req.byte_en = 4'b0011;
                        2'd1:    req.byte_en = 4'b0110;
                        2'd2:    req.byte_en = 4'b1100;
                        default: req.byte_en = 4'b0000;
                    endcase
                end
                F3_SB:   req.byte_en = 4'b0001 << offset;
                default: req.byte_en = 4'b0000;
            endcase
        end
    end

    // Data moved into the lane picked by the byte offset
    assign req.wdata = ex_op.store_data << {offset, 3'b000};

    // Execute stage only issues stores that fit in one word
    store_fits_word: assert final ($isunknown(ex_op.kind) || !is_store
        || !((ex_op.funct3 == F3_SH && offset == 2'd3)
        || (ex_op.funct3 == F3_SW && offset != 2'd0)));

endmodule

`default_nettype wire

/* src.f */
+incdir+include
design/riscv_isa_pkg.sv
design/dcache_pkg.sv
design/store_align.sv
design/mem_stage_pipe.sv
design/load_extract.sv
design/lsu_pipeline.sv
tb/tb_lsu_pipeline.sv

/* include/lsu_ref_model.svh */
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

// Cache model covers 64 words
localparam int REF_MEM_BYTES = 256;

function automatic dcache_req_t predict_request(mem_op_t op);
    dcache_req_t r;
    logic [1:0]  off;
    off       = op.result[1:0];
    r.addr    = {op.result[31:2], 2'b00};
    r.ctrl    = (op.kind == KIND_LOAD) ? DC_READ :
                (op.kind == KIND_STORE) ? DC_WRITE : DC_IDLE;
    r.byte_en = 4'b0000;
    if (op.kind == KIND_STORE)
    begin
        if (op.funct3 == F3_SW)
            r.byte_en = 4'b1111;
        else if (op.funct3 == F3_SH)
            r.byte_en = 4'b0011 << off;
        else if (op.funct3 == F3_SB)
            r.byte_en = 4'b0001 << off;
    end
    r.wdata   = op.store_data << (8 * off);
    return r;
endfunction

// Applies one accepted write to the byte array
function automatic void apply_store(ref logic [7:0] mem [REF_MEM_BYTES], input dcache_req_t r);
    int base;
    base = r.addr % REF_MEM_BYTES;
    for (int i = 0; i < 4; i++)
    begin
        if (r.byte_en[i])
            mem[base + i] = r.wdata[8*i +: 8];
    end
endfunction

function automatic word_t read_cache_word(ref logic [7:0] mem [REF_MEM_BYTES],
                                          input word_t addr);
    int base;
    base = {addr[31:2], 2'b00} % REF_MEM_BYTES;
    return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
endfunction

function automatic wb_t writeback_value(mem_op_t op, word_t word);
    wb_t   w;
    word_t lane;
    lane   = word >> (8 * op.result[1:0]);
    w.en   = (op.kind == KIND_LOAD || op.kind == KIND_ALU) && op.rd != 0;
    w.rd   = op.rd;
    w.data = op.result;
    if (op.kind == KIND_LOAD)
    begin
        case (op.funct3)
            F3_LB:   w.data = {{24{lane[7]}}, lane[7:0]};
            F3_LH:   w.data = {{16{lane[15]}}, lane[15:0]};
            F3_LBU:  w.data = {24'd0, lane[7:0]};
            F3_LHU:  w.data = {16'd0, lane[15:0]};
            default: w.data = word;
        endcase
    end
    return w;
endfunction

`endif

/* tb/tb_lsu_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_pipeline
    import riscv_isa_pkg::*;
    import dcache_pkg::*;
();

    localparam int MEM_LATENCY = 3;
    localparam int NUM_CYCLES  = 2000;
    localparam int DRAIN_LIMIT = 100;

    logic        CLK;
    logic        arst_n;
    logic        data_ready;
    mem_op_t     ex_op;
    word_t       rdata;
    dcache_req_t dcache_req;
    wb_t         wb;
    word_t       return_addr;

    `include "lsu_ref_model.svh"

    int         seed   = 7602;
    int         errors = 0;
    int         checks = 0;
    logic [7:0] cache_mem [REF_MEM_BYTES];
    mem_op_t    pipe_q [$];
    wb_t        exp_wb;
    word_t      exp_ret;
    wb_t        prev_wb;
    logic       prev_ready;
    int         drain_cycles;

    lsu_pipeline #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_dut (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .data_ready  (data_ready),
        .ex_op       (ex_op),
        .rdata       (rdata),
        .dcache_req  (dcache_req),
        .wb          (wb),
        .return_addr (return_addr)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Hard stop in case the stimulus loop itself stalls
    initial
    begin
        #((NUM_CYCLES + DRAIN_LIMIT + 20) * 40);
        $display("Simulation ran past its time limit");
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Aligned accesses only within the 64 word window
    function automatic mem_op_t random_op();
        mem_op_t    op;
        logic [1:0] off;
        op            = '0;
        op.kind       = op_kind_t'(rand_below(4));
        op.rd         = (rand_below(4) == 0) ? LINK_REG : reg_idx_t'(rand_below(32));
        op.store_data = $random(seed);
        if (op.kind == KIND_LOAD)
        begin
            case (rand_below(5))
                0:       op.funct3 = F3_LB;
                1:       op.funct3 = F3_LH;
                2:       op.funct3 = F3_LW;
                3:       op.funct3 = F3_LBU;
                default: op.funct3 = F3_LHU;
            endcase
        end
        else if (op.kind == KIND_STORE)
        begin
            case (rand_below(3))
                0:       op.funct3 = F3_SB;
                1:       op.funct3 = F3_SH;
                default: op.funct3 = F3_SW;
            endcase
        end
        if (op.kind == KIND_LOAD || op.kind == KIND_STORE)
        begin
            if (op.funct3[1:0] == 2'b10)
                off = 2'd0;
            else if (op.funct3[1:0] == 2'b01)
                off = 2'(2 * rand_below(2));
            else
                off = 2'(rand_below(4));
            op.result = word_t'(rand_below(64) * 4 + off);
        end
        else if (op.kind == KIND_ALU)
        begin
            op.result = $random(seed);
        end
        else
        begin
            op = '0;
        end
        return op;
    endfunction

    function automatic logic pipeline_empty();
        foreach (pipe_q[i])
        begin
            if (pipe_q[i].kind != KIND_IDLE)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // New op only after the previous one was accepted
    task automatic drive_cycle(input logic issue);
        if (prev_ready)
            ex_op = issue ? random_op() : mem_op_t'('0);
        data_ready = (rand_below(4) != 0);
        if (pipe_q[0].kind == KIND_LOAD)
            rdata = read_cache_word(cache_mem, pipe_q[0].result);
        else
            rdata = $random(seed);
        exp_wb = writeback_value(pipe_q[0], rdata);
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        dcache_req_t exp_req;
        exp_req = predict_request(ex_op);
        check_value("dcache_req.ctrl", dcache_req.ctrl, exp_req.ctrl);
        check_value("dcache_req.addr", dcache_req.addr, exp_req.addr);
        check_value("dcache_req.byte_en", dcache_req.byte_en, exp_req.byte_en);
        check_value("dcache_req.wdata", dcache_req.wdata, exp_req.wdata);
        check_value("wb.en", wb.en, exp_wb.en);
        check_value("wb.rd", wb.rd, exp_wb.rd);
        check_value("wb.data", wb.data, exp_wb.data);
        check_value("return_addr", return_addr, exp_ret);
        if (!prev_ready)
        begin
            checks++;
            assert (wb === prev_wb)
            else
            begin
                errors++;
                $display("** Error: wb = %h, expected %h held across stall at %0t",
                         wb, prev_wb, $time);
            end
        end
    endtask

    // Model state moves only on accepting edges
    always @(posedge CLK)
    begin
        if (arst_n && data_ready)
        begin
            if (exp_wb.en && exp_wb.rd == LINK_REG)
                exp_ret = exp_wb.data;
            if (ex_op.kind == KIND_STORE)
                apply_store(cache_mem, predict_request(ex_op));
            pipe_q.push_back(ex_op);
            void'(pipe_q.pop_front());
        end
    end

    task automatic run_cycle(input logic issue);
        @(negedge CLK);
        prev_ready = data_ready;
        drive_cycle(issue);
        #1;
        check_outputs();
        prev_wb = wb;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        arst_n     = 1'b0;
        data_ready = 1'b0;
        ex_op      = '0;
        rdata      = '0;
        exp_wb     = '0;
        exp_ret    = '0;
        prev_wb    = '0;
        prev_ready = 1'b0;
        for (int i = 0; i < REF_MEM_BYTES; i++)
        begin
            cache_mem[i] = 8'((i * 37 + 11) ^ (i >> 3));
        end
        // Writeback register plus the memory stages
        for (int i = 0; i <= MEM_LATENCY; i++)
        begin
            pipe_q.push_back(mem_op_t'('0));
        end
        repeat (4) @(negedge CLK);
        arst_n = 1'b1;
        #1;
        check_value("return_addr", return_addr, 32'd0);
        check_value("wb.en", wb.en, 32'd0);

        for (int c = 0; c < NUM_CYCLES; c++)
        begin
            run_cycle(1'b1);
        end

        drain_cycles = 0;
        while ((!pipeline_empty() || !prev_ready) && drain_cycles < DRAIN_LIMIT)
        begin
            run_cycle(1'b0);
            drain_cycles++;
        end
        checks++;
        assert (pipeline_empty() && prev_ready)
        else
        begin
            errors++;
            $display("Pipeline did not drain within %0d cycles", DRAIN_LIMIT);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
